/* verilog/game_pkg.sv */
package game_pkg;

    //////////////////////////////////////////////////
    // board geometry
    //////////////////////////////////////////////////
    localparam int board_side = 4;              // fixed by the rotation maps.
    localparam int num_cells = board_side * board_side;
    localparam int cell_idx_w = 4;
    localparam int spawn_roll_w = 6;
    localparam int tile_w_default = 5;

    // spawned tile exponents.
    localparam int spawn_exp_two = 1;
    localparam int spawn_exp_four = 2;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        dir_left = 2'd0,
        dir_up = 2'd1,
        dir_right = 2'd2,
        dir_down = 2'd3
    } move_dir_e;

    typedef enum logic [1:0] {
        st_idle,
        st_spawn
    } ctrl_state_e;

    // board register write source.
    typedef enum logic [1:0] {
        wr_hold,
        wr_load,
        wr_merge,
        wr_spawn
    } board_wr_e;

endpackage

/* verilog/board_rotator.sv */
module board_rotator #(
    parameter int tile_w = 5,
    parameter bit inverse = 1'b0
) (
    input  game_pkg::move_dir_e                       dir,
    input  logic [game_pkg::num_cells*tile_w-1:0]     board_in,
    output logic [game_pkg::num_cells*tile_w-1:0]     board_out
);
    import game_pkg::*;

    // source cell of line r, position c in the column-0 orientation.
    function automatic int unsigned src_idx(
        input move_dir_e d,
        input int unsigned r,
        input int unsigned c
    );
        case (d)
            dir_left: begin
                src_idx = r * board_side + c;
            end
            dir_up: begin
                src_idx = c * board_side + r;               // column r, top first.
            end
            dir_right: begin
                src_idx = r * board_side + (board_side - 1 - c);
            end
            default: begin
                src_idx = (board_side - 1 - c) * board_side + r; // dir_down.
            end
        endcase
    endfunction

    always_comb begin
        int unsigned src;
        int unsigned dst;
        board_out = '0;
        for (int r = 0; r < board_side; r++) begin
            for (int c = 0; c < board_side; c++) begin
                src = src_idx(dir, r, c);
                dst = r * board_side + c;
                if (inverse) begin
                    // scatter back through the same map.
                    board_out[src*tile_w +: tile_w] = board_in[dst*tile_w +: tile_w];
                end else begin
                    board_out[dst*tile_w +: tile_w] = board_in[src*tile_w +: tile_w];
                end
            end
        end
    end

endmodule

/* verilog/line_merge.sv */
module line_merge #(
    parameter int tile_w = 5
) (
    input  logic [game_pkg::board_side*tile_w-1:0]    line_in,
    output logic [game_pkg::board_side*tile_w-1:0]    line_out,
    output logic                                      movable
);
    import game_pkg::*;

    logic [tile_w-1:0]      comp [board_side];
    logic [tile_w-1:0]      res [board_side];
    logic [board_side-1:0]  pair_eq;

    //////////////////////////////////////////////////
    // compact toward position 0
    //////////////////////////////////////////////////
    always_comb begin
        int unsigned n;
        n = 0;
        for (int i = 0; i < board_side; i++) begin
            comp[i] = '0;
        end
        for (int i = 0; i < board_side; i++) begin
            if (line_in[i*tile_w +: tile_w] != '0) begin
                comp[n] = line_in[i*tile_w +: tile_w];
                n++;
            end
        end
    end

    // equal nonzero neighbours after compaction.
    for (genvar j = 0; j < board_side - 1; j++) begin : g_pair
        assign pair_eq[j] = (comp[j] != '0) && (comp[j] == comp[j+1]);
    end
    assign pair_eq[board_side-1] = 1'b0;                // nothing beyond the last slot.

    //////////////////////////////////////////////////
    // pairwise merge, scanning from position 0
    //////////////////////////////////////////////////
    always_comb begin
        int unsigned k;
        logic skip;
        k = 0;
        skip = 1'b0;
        for (int i = 0; i < board_side; i++) begin
            res[i] = '0;
        end
        for (int j = 0; j < board_side; j++) begin
            if (skip) begin
                skip = 1'b0;                            // partner already consumed.
            end else if (pair_eq[j]) begin
                res[k] = comp[j] + 1'b1;
                k++;
                skip = 1'b1;
            end else begin
                res[k] = comp[j];
                k++;
            end
        end
    end

    for (genvar i = 0; i < board_side; i++) begin : g_pack
        assign line_out[i*tile_w +: tile_w] = res[i];
    end

    assign movable = (line_out != line_in);

    a_empty_row_still: assert final (line_in != '0 || !movable)
        else $error("line_merge: empty row flagged movable");

endmodule

/* verilog/board_merge.sv */
module board_merge #(
    parameter int tile_w = 5
) (
    input  game_pkg::move_dir_e                       cur_dir,
    input  logic [game_pkg::num_cells*tile_w-1:0]     board,
    output logic [game_pkg::num_cells*tile_w-1:0]     merged_board,
    output logic                                      movable
);
    import game_pkg::*;

    localparam int line_w = board_side * tile_w;

    logic [num_cells*tile_w-1:0]    rotated;
    logic [num_cells*tile_w-1:0]    merged;
    logic [board_side-1:0]          row_movable;

    board_rotator #(.tile_w(tile_w), .inverse(1'b0)) i_rotate (
        .dir        (cur_dir),
        .board_in   (board),
        .board_out  (rotated)
    );

    // each row merges toward column 0 on its own.
    for (genvar r = 0; r < board_side; r++) begin : g_row
        line_merge #(.tile_w(tile_w)) i_line_merge (
            .line_in    (rotated[r*line_w +: line_w]),
            .line_out   (merged[r*line_w +: line_w]),
            .movable    (row_movable[r])
        );
    end

    board_rotator #(.tile_w(tile_w), .inverse(1'b1)) i_unrotate (
        .dir        (cur_dir),
        .board_in   (merged),
        .board_out  (merged_board)
    );

    assign movable = |row_movable;

endmodule

/* verilog/tile_spawner.sv */
module tile_spawner #(
    parameter int tile_w = 5
) (
    input  logic [game_pkg::num_cells*tile_w-1:0]     board,
    input  logic [game_pkg::cell_idx_w-1:0]           spawn_pos,
    input  logic [game_pkg::spawn_roll_w-1:0]         spawn_roll,
    output logic [game_pkg::num_cells*tile_w-1:0]     spawned_board,
    output logic                                      cell_empty
);
    import game_pkg::*;

    logic [tile_w-1:0] target;
    logic [tile_w-1:0] new_tile;

    assign target = board[spawn_pos*tile_w +: tile_w];
    assign cell_empty = (target == '0);

    // a zero roll gives the rarer 4 tile.
    assign new_tile = (spawn_roll == '0) ? tile_w'(spawn_exp_four) : tile_w'(spawn_exp_two);

    always_comb begin
        spawned_board = board;
        spawned_board[spawn_pos*tile_w +: tile_w] = new_tile;
    end

endmodule

/* verilog/board_regs.sv */
module board_regs #(
    parameter int tile_w = 5
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  game_pkg::board_wr_e                       wr_sel,
    input  logic [game_pkg::num_cells*tile_w-1:0]     board_in,
    input  logic [game_pkg::num_cells*tile_w-1:0]     merged_board,
    input  logic [game_pkg::num_cells*tile_w-1:0]     spawned_board,
    output logic [game_pkg::num_cells*tile_w-1:0]     board
);
    import game_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            board <= '0;                                // empty board.
        end else begin
            case (wr_sel)
                wr_load: begin
                    board <= board_in;
                end
                wr_merge: begin
                    board <= merged_board;
                end
                wr_spawn: begin
                    board <= spawned_board;
                end
                default: begin
                    board <= board;                     // wr_hold.
                end
            endcase
        end
    end

    a_wr_sel_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(wr_sel)
    ) else $error("board_regs: wr_sel unknown");

endmodule

/* verilog/move_ctrl.sv */
module move_ctrl (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    board_load,
    input  logic                    move_valid,
    input  game_pkg::move_dir_e     move_dir,
    input  logic                    movable,
    input  logic                    cell_empty,
    output game_pkg::move_dir_e     cur_dir,
    output game_pkg::board_wr_e     wr_sel,
    output logic                    busy,
    output logic                    move_done,
    output logic                    moved
);
    import game_pkg::*;

    ctrl_state_e    state;
    ctrl_state_e    state_nxt;
    move_dir_e      dir_q;
    logic           done_nxt;
    logic           moved_nxt;

    // new direction goes straight through on the command cycle.
    assign cur_dir = (state == st_idle && move_valid) ? move_dir : dir_q;
    assign busy = (state == st_spawn);

    //////////////////////////////////////////////////
    // next state and write source
    //////////////////////////////////////////////////
    always_comb begin
        state_nxt = state;
        wr_sel = wr_hold;
        done_nxt = 1'b0;
        moved_nxt = 1'b0;
        case (state)
            st_idle: begin
                if (move_valid) begin                   // move wins over a concurrent load.
                    if (movable) begin
                        wr_sel = wr_merge;
                        state_nxt = st_spawn;
                    end else begin
                        done_nxt = 1'b1;                // nothing changed.
                    end
                end else if (board_load) begin
                    wr_sel = wr_load;
                end
            end
            st_spawn: begin
                if (cell_empty) begin
                    wr_sel = wr_spawn;
                    state_nxt = st_idle;
                    done_nxt = 1'b1;
                    moved_nxt = 1'b1;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            dir_q <= dir_left;
            move_done <= 1'b0;
            moved <= 1'b0;
        end else begin
            state <= state_nxt;
            dir_q <= cur_dir;
            move_done <= done_nxt;
            moved <= moved_nxt;
        end
    end

    //////////////////////////////////////////////////
    // protocol checks
    //////////////////////////////////////////////////
    a_no_cmd_busy: assert property (
        @(posedge clk) disable iff (!arst_n) busy |-> !(move_valid || board_load)
    ) else $error("move_ctrl: command while busy");

    // a second pulse needs a fresh command.
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) move_done |=> (!move_done || $past(move_valid))
    ) else $error("move_ctrl: move_done held high");

endmodule

/* verilog/game_top.sv */
module game_top #(
    parameter int tile_w = game_pkg::tile_w_default
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      board_load,
    input  logic [game_pkg::num_cells*tile_w-1:0]     board_in,
    input  logic                                      move_valid,
    input  game_pkg::move_dir_e                       move_dir,
    input  logic [game_pkg::cell_idx_w-1:0]           spawn_pos,
    input  logic [game_pkg::spawn_roll_w-1:0]         spawn_roll,
    output logic                                      busy,
    output logic                                      move_done,
    output logic                                      moved,
    output logic [game_pkg::num_cells*tile_w-1:0]     board
);
    import game_pkg::*;

    logic [num_cells*tile_w-1:0]    merged_board;
    logic [num_cells*tile_w-1:0]    spawned_board;
    logic                           movable;
    logic                           cell_empty;
    move_dir_e                      cur_dir;
    board_wr_e                      wr_sel;

    move_ctrl i_move_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .board_load (board_load),
        .move_valid (move_valid),
        .move_dir   (move_dir),
        .movable    (movable),
        .cell_empty (cell_empty),
        .cur_dir    (cur_dir),
        .wr_sel     (wr_sel),
        .busy       (busy),
        .move_done  (move_done),
        .moved      (moved)
    );

    board_regs #(.tile_w(tile_w)) i_board_regs (
        .clk            (clk),
        .arst_n         (arst_n),
        .wr_sel         (wr_sel),
        .board_in       (board_in),
        .merged_board   (merged_board),
        .spawned_board  (spawned_board),
        .board          (board)
    );

    board_merge #(.tile_w(tile_w)) i_board_merge (
        .cur_dir        (cur_dir),
        .board          (board),
        .merged_board   (merged_board),
        .movable        (movable)
    );

    tile_spawner #(.tile_w(tile_w)) i_tile_spawner (
        .board          (board),
        .spawn_pos      (spawn_pos),
        .spawn_roll     (spawn_roll),
        .spawned_board  (spawned_board),
        .cell_empty     (cell_empty)
    );

endmodule

/* verif/game_tb.sv */
module game_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import game_pkg::*;

    localparam int tile_w = tile_w_default;
    localparam int board_w = num_cells * tile_w;
    localparam int line_w = board_side * tile_w;
    localparam int n_random = 40;
    localparam int n_directed_cmds = 13;                // 5 loads, 8 moves.
    localparam int n_cmds = n_directed_cmds + 2 * n_random;
    localparam int timeout_cycles = n_cmds * 20 + 200;

    logic                       clk;
    logic                       arst_n;
    logic                       board_load;
    logic [board_w-1:0]         board_in;
    logic                       move_valid;
    move_dir_e                  move_dir;
    logic [cell_idx_w-1:0]      spawn_pos;
    logic [spawn_roll_w-1:0]    spawn_roll;
    logic                       busy;
    logic                       move_done;
    logic                       moved;
    logic [board_w-1:0]         board;

    // model state.
    logic [board_w-1:0]         exp_board;
    logic [board_w-1:0]         mid_board;
    logic                       exp_moved;
    logic                       offer_empty;

    int err_count = 0;
    int n_loads = 0;
    int n_moves = 0;
    int n_spawns = 0;
    int cycles = 0;

    game_top #(.tile_w(tile_w)) i_game_top (
        .clk        (clk),
        .arst_n     (arst_n),
        .board_load (board_load),
        .board_in   (board_in),
        .move_valid (move_valid),
        .move_dir   (move_dir),
        .spawn_pos  (spawn_pos),
        .spawn_roll (spawn_roll),
        .busy       (busy),
        .move_done  (move_done),
        .moved      (moved),
        .board      (board)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign offer_empty = (mid_board[spawn_pos*tile_w +: tile_w] == '0);

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    // board cell holding position pos of line `line` once the move points at column 0.
    function automatic int unsigned cell_at(input move_dir_e d, input int unsigned line,
                                            input int unsigned pos);
        case (d)
            dir_left:  return line * board_side + pos;
            dir_up:    return pos * board_side + line;
            dir_right: return line * board_side + (board_side - 1 - pos);
            default:   return (board_side - 1 - pos) * board_side + line;
        endcase
    endfunction

    function automatic logic [board_w-1:0] ref_move(input logic [board_w-1:0] b,
                                                    input move_dir_e d);
        logic [board_w-1:0] res;
        int q[$];
        int merged[$];
        int unsigned idx;
        res = '0;
        for (int r = 0; r < board_side; r++) begin
            q.delete();
            merged.delete();
            for (int c = 0; c < board_side; c++) begin
                idx = cell_at(d, r, c);
                if (b[idx*tile_w +: tile_w] != '0) begin
                    q.push_back(int'(b[idx*tile_w +: tile_w]));
                end
            end
            while (q.size() > 0) begin
                if (q.size() > 1 && q[0] == q[1]) begin
                    merged.push_back(q[0] + 1);         // pair becomes one tile.
                    void'(q.pop_front());
                    void'(q.pop_front());
                end else begin
                    merged.push_back(q[0]);
                    void'(q.pop_front());
                end
            end
            for (int c = 0; c < merged.size(); c++) begin
                idx = cell_at(d, r, c);
                res[idx*tile_w +: tile_w] = tile_w'(merged[c]);
            end
        end
        return res;
    endfunction

    function automatic logic [board_w-1:0] ref_spawn(input logic [board_w-1:0] b,
                                                     input logic [cell_idx_w-1:0] pos,
                                                     input logic [spawn_roll_w-1:0] roll);
        logic [board_w-1:0] res;
        res = b;
        res[pos*tile_w +: tile_w] = (roll == 0) ? tile_w'(2) : tile_w'(1); // 4 on a zero roll.
        return res;
    endfunction

    function automatic logic [line_w-1:0] make_line(input int t0, input int t1,
                                                    input int t2, input int t3);
        return {tile_w'(t3), tile_w'(t2), tile_w'(t1), tile_w'(t0)};
    endfunction

    function automatic logic [board_w-1:0] rand_board();
        logic [board_w-1:0] b;
        b = '0;
        for (int i = 0; i < num_cells; i++) begin
            if ($urandom_range(0, 1) == 1) begin
                b[i*tile_w +: tile_w] = tile_w'($urandom_range(1, 4));
            end
        end
        return b;
    endfunction

    // random cell that is occupied, or empty when occupied is low.
    function automatic logic [cell_idx_w-1:0] pick_cell(input logic [board_w-1:0] b,
                                                        input bit occupied);
        logic [cell_idx_w-1:0] p;
        p = cell_idx_w'($urandom);
        while ((b[p*tile_w +: tile_w] != '0) != occupied) begin
            p = cell_idx_w'($urandom);
        end
        return p;
    endfunction

    //////////////////////////////////////////////////
    // stimulus tasks enter and leave at a falling edge
    //////////////////////////////////////////////////
    task automatic load_board(input logic [board_w-1:0] b);
        board_load = 1'b1;
        board_in = b;
        exp_board = b;
        n_loads++;
        @(negedge clk);
        board_load = 1'b0;
    endtask

    task automatic do_move(input move_dir_e d);
        logic [cell_idx_w-1:0] pos;
        logic [spawn_roll_w-1:0] roll;
        int n_occ;
        mid_board = ref_move(exp_board, d);
        exp_moved = (mid_board != exp_board);
        move_valid = 1'b1;
        move_dir = d;
        n_moves++;
        @(negedge clk);
        move_valid = 1'b0;
        if (exp_moved) begin
            n_occ = $urandom_range(0, 2);
            for (int i = 0; i < n_occ; i++) begin
                spawn_pos = pick_cell(mid_board, 1'b1);     // refused offer.
                spawn_roll = spawn_roll_w'($urandom);
                @(negedge clk);
            end
            pos = pick_cell(mid_board, 1'b0);
            roll = ($urandom_range(0, 3) == 0) ? '0 : spawn_roll_w'($urandom_range(1, 63));
            spawn_pos = pos;
            spawn_roll = roll;
            exp_board = ref_spawn(mid_board, pos, roll);
            n_spawns++;
        end
        while (!move_done) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    a_reset_state: assert property (@(posedge clk)
        $rose(arst_n) |-> !busy && !move_done && !moved && board == '0)
        else begin
            err_count++;
            $display("Error: reset state busy %h move_done %h moved %h board %h",
                     $sampled(busy), $sampled(move_done), $sampled(moved), $sampled(board));
        end

    a_load: assert property (@(posedge clk) disable iff (!arst_n)
        board_load |=> board == exp_board)
        else begin
            err_count++;
            $display("Error: board after load expected %h actual %h", exp_board, $sampled(board));
        end

    a_move_start: assert property (@(posedge clk) disable iff (!arst_n)
        move_valid && exp_moved |=> busy && !move_done)
        else begin
            err_count++;
            $display("Error: busy expected 1 actual %h, move_done %h",
                     $sampled(busy), $sampled(move_done));
        end

    a_move_still: assert property (@(posedge clk) disable iff (!arst_n)
        move_valid && !exp_moved |=> move_done && !moved && !busy)
        else begin
            err_count++;
            $display("Error: unmovable move_done %h moved %h busy %h",
                     $sampled(move_done), $sampled(moved), $sampled(busy));
        end

    a_merged_board: assert property (@(posedge clk) disable iff (!arst_n)
        busy |-> board == mid_board)
        else begin
            err_count++;
            $display("Error: board in spawn expected %h actual %h", mid_board, $sampled(board));
        end

    a_spawn_wait: assert property (@(posedge clk) disable iff (!arst_n)
        busy && !offer_empty |=> busy && !move_done)
        else begin
            err_count++;
            $display("Error: on occupied offer busy expected 1 actual %h, move_done %h",
                     $sampled(busy), $sampled(move_done));
        end

    a_spawn_take: assert property (@(posedge clk) disable iff (!arst_n)
        busy && offer_empty |=> !busy && move_done && moved)
        else begin
            err_count++;
            $display("Error: after spawn busy %h move_done %h moved %h",
                     $sampled(busy), $sampled(move_done), $sampled(moved));
        end

    a_done_board: assert property (@(posedge clk) disable iff (!arst_n)
        move_done |-> board == exp_board && moved == exp_moved)
        else begin
            err_count++;
            $display("Error: board expected %h actual %h, moved expected %h actual %h",
                     exp_board, $sampled(board), exp_moved, $sampled(moved));
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: run stopped after %0d cycles with %0d errors", cycles, err_count);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(32'hd2d1));
        arst_n = 1'b0;
        board_load = 1'b0;
        board_in = '0;
        move_valid = 1'b0;
        move_dir = dir_left;
        spawn_pos = '0;
        spawn_roll = '0;
        exp_board = '0;
        mid_board = '0;
        exp_moved = 1'b0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // row corner cases with left moves.
        load_board({make_line(1, 0, 1, 2), make_line(3, 3, 3, 3),
                    make_line(2, 2, 2, 0), make_line(1, 1, 0, 0)});
        do_move(dir_left);
        load_board({make_line(0, 6, 6, 6), make_line(4, 0, 0, 4),
                    make_line(1, 2, 1, 2), make_line(0, 0, 0, 5)});
        do_move(dir_left);
        load_board({make_line(7, 7, 0, 7), make_line(0, 0, 0, 0),
                    make_line(0, 1, 1, 0), make_line(2, 2, 2, 2)});
        do_move(dir_left);

        // full board with no equal neighbours.
        load_board({make_line(3, 4, 3, 4), make_line(1, 2, 1, 2),
                    make_line(3, 4, 3, 4), make_line(1, 2, 1, 2)});
        do_move(dir_left);
        do_move(dir_up);
        do_move(dir_right);
        do_move(dir_down);
        load_board({make_line(4, 5, 6, 0), make_line(0, 0, 0, 0),
                    make_line(3, 0, 0, 0), make_line(1, 2, 0, 0)});
        do_move(dir_left);

        repeat (n_random) begin
            load_board(rand_board());
            do_move(move_dir_e'($urandom_range(0, 3)));
        end

        repeat (4) @(negedge clk);
        $display("errors %0d, loads %0d, moves %0d, spawns %0d, cycles %0d",
                 err_count, n_loads, n_moves, n_spawns, cycles);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/game_pkg.sv
verilog/board_rotator.sv
verilog/line_merge.sv
verilog/board_merge.sv
verilog/tile_spawner.sv
verilog/board_regs.sv
verilog/move_ctrl.sv
verilog/game_top.sv
verif/game_tb.sv
